// File: common/geometryPkg.sv
`default_nettype none

package geometryPkg;

	// Screen coordinate in pixels
	typedef logic [15:0] coordT;

	// x in the upper half of the word
	typedef struct packed {
		coordT x;
		coordT y;
	} pointT;

	// Character or hitbox, size measured from pos
	typedef struct packed {
		pointT pos;
		pointT size;
	} boxT;

	// Side of the character where a hitbox goes
	typedef enum logic [1:0] {
		left  = 2'd0,
		right = 2'd1,
		up    = 2'd2,
		down  = 2'd3
	} dirT;

endpackage

`default_nettype wire

// File: common/combatPkg.sv
`default_nettype none

package combatPkg;

	// Controller word as sent by the input port each frame
	typedef struct packed {
		logic [4:0] spareHi;
		logic       facingRight;
		logic [1:0] spareMid;
		logic       smashL;
		logic       smashR;
		logic       smashU;
		logic       smashD;
		logic [1:0] spareLo;
		logic       bButton;
		logic       aButton;
		logic [7:0] stickX;
		logic [7:0] stickY;
	} controlsT;

	typedef enum logic [3:0] {
		none     = 4'd0,
		smashL   = 4'd1,
		smashR   = 4'd2,
		smashU   = 4'd3,
		smashD   = 4'd4,
		jab      = 4'd5,
		specialN = 4'd6,
		specialL = 4'd7,
		specialR = 4'd8,
		specialU = 4'd9,
		specialD = 4'd10
	} attackKindT;

	// One per landed attack
	typedef struct packed {
		logic       valid;
		attackKindT kind;
	} hitReportT;

	// Top three stick bits all zero
	localparam logic [7:0] stickLowMax = 8'd31;
	// Top three stick bits all one
	localparam logic [7:0] stickHighMin = 8'd224;

endpackage

`default_nettype wire

// File: attack/attackDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module attackDecoder (
	input  wire combatPkg::controlsT controls,
	output combatPkg::attackKindT    kind
);

	logic stickLeft;
	logic stickRight;
	logic stickUp;
	logic stickDown;

	assign stickLeft  = controls.stickX <= combatPkg::stickLowMax;
	assign stickRight = controls.stickX >= combatPkg::stickHighMin;
	assign stickUp    = controls.stickY >= combatPkg::stickHighMin;
	assign stickDown  = controls.stickY <= combatPkg::stickLowMax;

	// Smash buttons first, then A, then B with the stick
	always_comb begin
		kind = combatPkg::none;
		if (controls.smashL) begin
			kind = combatPkg::smashL;
		end else if (controls.smashR) begin
			kind = combatPkg::smashR;
		end else if (controls.smashU) begin
			kind = combatPkg::smashU;
		end else if (controls.smashD) begin
			kind = combatPkg::smashD;
		end else if (controls.aButton) begin
			kind = combatPkg::jab;
		end else if (controls.bButton) begin
			// Horizontal tilt beats vertical
			if (stickLeft) begin
				kind = combatPkg::specialL;
			end else if (stickRight) begin
				kind = combatPkg::specialR;
			end else if (stickUp) begin
				kind = combatPkg::specialU;
			end else if (stickDown) begin
				kind = combatPkg::specialD;
			end else begin
				kind = combatPkg::specialN;
			end
		end
	end

endmodule

`default_nettype wire

// File: attack/attackUnit.sv
`timescale 1ns/100ps
`default_nettype none

module attackUnit #(
	parameter int jabWindup  = 4,
	parameter int longWindup = 8,
	parameter int activeLen  = 4
) (
	input  wire                      clock,
	input  wire                      rstN,
	input  wire combatPkg::controlsT controls,
	input  wire geometryPkg::boxT    self,
	input  wire                      grant,
	input  wire                      overlap,
	output logic                     req,
	output geometryPkg::boxT         hitbox,
	output combatPkg::hitReportT     hit,
	output logic                     busy
);

	localparam int maxWindup = (jabWindup > longWindup) ? jabWindup : longWindup;
	localparam int maxPhase  = (maxWindup > activeLen) ? maxWindup : activeLen;
	localparam int cntWidth  = $clog2(maxPhase + 1);

	typedef enum logic [1:0] {
		idle,
		windup,
		active
	} stateT;

	stateT                 state;
	logic [cntWidth-1:0]   count;
	logic [cntWidth-1:0]   windupLast;
	combatPkg::attackKindT decoded;
	combatPkg::attackKindT kindQ;
	combatPkg::attackKindT hitKindQ;
	logic                  facingQ;
	logic                  landed;
	logic                  hitValidQ;
	geometryPkg::dirT      dir;
	geometryPkg::coordT    halfW;
	geometryPkg::coordT    halfH;
	geometryPkg::coordT    quarterW;
	geometryPkg::coordT    quarterH;

	attackDecoder decoder0 (
		.controls(controls),
		.kind    (decoded)
	);

	assign windupLast = (decoded == combatPkg::jab) ? cntWidth'(jabWindup - 1)
		: cntWidth'(longWindup - 1);

	always_ff @(posedge clock) begin
		if (!rstN) begin
			state     <= idle;
			count     <= '0;
			landed    <= 1'b0;
			hitValidQ <= 1'b0;
		end else begin
			// Only the first granted overlap of an attack counts
			hitValidQ <= (state == active) && grant && overlap && !landed;
			case (state)
				idle: begin
					if (decoded != combatPkg::none) begin
						state  <= windup;
						count  <= windupLast;
						landed <= 1'b0;
					end
				end
				windup: begin
					if (count == '0) begin
						state <= active;
						count <= cntWidth'(activeLen - 1);
					end else begin
						count <= count - 1'b1;
					end
				end
				active: begin
					if (grant && overlap) begin
						landed <= 1'b1;
					end
					if (count == '0) begin
						state <= idle;
					end else begin
						count <= count - 1'b1;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// Tracks controls until the attack starts
	always_ff @(posedge clock) begin
		if (state == idle) begin
			kindQ   <= decoded;
			facingQ <= controls.facingRight;
		end
		hitKindQ <= kindQ;
	end

	always_comb begin
		case (kindQ)
			combatPkg::smashL, combatPkg::specialL: dir = geometryPkg::left;
			combatPkg::smashR, combatPkg::specialR: dir = geometryPkg::right;
			combatPkg::smashU, combatPkg::specialU: dir = geometryPkg::up;
			combatPkg::smashD, combatPkg::specialD: dir = geometryPkg::down;
			default: dir = facingQ ? geometryPkg::right : geometryPkg::left;
		endcase
	end

	assign halfW    = self.size.x >> 1;
	assign halfH    = self.size.y >> 1;
	assign quarterW = self.size.x >> 2;
	assign quarterH = self.size.y >> 2;

	// Half-size box next to the character on the attack side
	always_comb begin
		hitbox.size.x = halfW;
		hitbox.size.y = halfH;
		case (dir)
			geometryPkg::left: begin
				hitbox.pos.x = self.pos.x - halfW;
				hitbox.pos.y = self.pos.y + quarterH;
			end
			geometryPkg::right: begin
				hitbox.pos.x = self.pos.x + self.size.x;
				hitbox.pos.y = self.pos.y + quarterH;
			end
			geometryPkg::up: begin
				hitbox.pos.x = self.pos.x + quarterW;
				hitbox.pos.y = self.pos.y + self.size.y;
			end
			default: begin
				hitbox.pos.x = self.pos.x + quarterW;
				hitbox.pos.y = self.pos.y - quarterH;
			end
		endcase
	end

	assign req  = (state == active);
	assign busy = (state != idle);
	assign hit  = '{valid: hitValidQ, kind: hitKindQ};

	// A report needs an active cycle and a latched attack kind
	hitFromActive: assert property (@(posedge clock) disable iff (!rstN)
		hit.valid |-> $past(state == active) && hit.kind != combatPkg::none);

	// Each request lasts exactly the active phase
	reqActiveLen: assert property (@(posedge clock) disable iff (!rstN)
		$fell(req) |-> $past(req, activeLen) && !$past(req, activeLen + 1));

endmodule

`default_nettype wire

// File: hw/hitArbiter.sv
`timescale 1ns/100ps
`default_nettype none

module hitArbiter (
	input  wire                   clock,
	input  wire                   rstN,
	input  wire                   req1,
	input  wire                   req2,
	input  wire geometryPkg::boxT hitbox1,
	input  wire geometryPkg::boxT hitbox2,
	input  wire geometryPkg::boxT char1,
	input  wire geometryPkg::boxT char2,
	output logic                  grant1,
	output logic                  grant2,
	output logic                  overlap
);

	logic             favor2;
	geometryPkg::boxT attackBox;
	geometryPkg::boxT targetBox;
	logic [16:0]      attackEndX;
	logic [16:0]      attackEndY;
	logic [16:0]      targetEndX;
	logic [16:0]      targetEndY;
	logic             overlapX;
	logic             overlapY;

	// Ties go to whoever was not served last
	assign grant1 = req1 && (!req2 || !favor2);
	assign grant2 = req2 && (!req1 || favor2);

	always_ff @(posedge clock) begin
		if (!rstN) begin
			favor2 <= 1'b0;
		end else if (grant1) begin
			favor2 <= 1'b1;
		end else if (grant2) begin
			favor2 <= 1'b0;
		end
	end

	// Each player swings at the other one
	assign attackBox = grant2 ? hitbox2 : hitbox1;
	assign targetBox = grant2 ? char1 : char2;

	// One bit wider so far edges do not wrap
	assign attackEndX = {1'b0, attackBox.pos.x} + attackBox.size.x;
	assign attackEndY = {1'b0, attackBox.pos.y} + attackBox.size.y;
	assign targetEndX = {1'b0, targetBox.pos.x} + targetBox.size.x;
	assign targetEndY = {1'b0, targetBox.pos.y} + targetBox.size.y;

	assign overlapX = ({1'b0, attackBox.pos.x} < targetEndX)
		&& ({1'b0, targetBox.pos.x} < attackEndX);
	assign overlapY = ({1'b0, attackBox.pos.y} < targetEndY)
		&& ({1'b0, targetBox.pos.y} < attackEndY);

	assign overlap = (grant1 || grant2) && overlapX && overlapY;

	// A requester that loses a tie is served on the next cycle
	waitBound1: assert property (@(posedge clock) disable iff (!rstN)
		req1 && !grant1 |=> grant1 || !req1);

	waitBound2: assert property (@(posedge clock) disable iff (!rstN)
		req2 && !grant2 |=> grant2 || !req2);

endmodule

`default_nettype wire

// File: hw/attackCoprocessor.sv
`timescale 1ns/100ps
`default_nettype none

module attackCoprocessor #(
	parameter int jabWindup  = 4,
	parameter int longWindup = 8,
	parameter int activeLen  = 4
) (
	input  wire                      clock,
	input  wire                      rstN,
	input  wire combatPkg::controlsT controls1,
	input  wire combatPkg::controlsT controls2,
	input  wire geometryPkg::boxT    char1,
	input  wire geometryPkg::boxT    char2,
	output combatPkg::hitReportT     hit1,
	output combatPkg::hitReportT     hit2,
	output logic                     busy1,
	output logic                     busy2
);

	logic             req1;
	logic             req2;
	logic             grant1;
	logic             grant2;
	logic             overlap;
	geometryPkg::boxT hitbox1;
	geometryPkg::boxT hitbox2;

	attackUnit #(
		.jabWindup (jabWindup),
		.longWindup(longWindup),
		.activeLen (activeLen)
	) unit1 (
		.clock   (clock),
		.rstN    (rstN),
		.controls(controls1),
		.self    (char1),
		.grant   (grant1),
		.overlap (overlap),
		.req     (req1),
		.hitbox  (hitbox1),
		.hit     (hit1),
		.busy    (busy1)
	);

	attackUnit #(
		.jabWindup (jabWindup),
		.longWindup(longWindup),
		.activeLen (activeLen)
	) unit2 (
		.clock   (clock),
		.rstN    (rstN),
		.controls(controls2),
		.self    (char2),
		.grant   (grant2),
		.overlap (overlap),
		.req     (req2),
		.hitbox  (hitbox2),
		.hit     (hit2),
		.busy    (busy2)
	);

	// Single overlap tester shared by both players
	hitArbiter arbiter0 (
		.clock  (clock),
		.rstN   (rstN),
		.req1   (req1),
		.req2   (req2),
		.hitbox1(hitbox1),
		.hitbox2(hitbox2),
		.char1  (char1),
		.char2  (char2),
		.grant1 (grant1),
		.grant2 (grant2),
		.overlap(overlap)
	);

endmodule

`default_nettype wire

// File: tb/attackCoprocessorTb.sv
`timescale 1ns/100ps
`default_nettype none

module attackCoprocessorTb;

	localparam int jabWindup     = 2;
	localparam int longWindup    = 4;
	localparam int activeLen     = 3;
	localparam int numRounds     = 80;
	// Launch edge, longest attack, closing edge and some slack
	localparam int roundLimit    = longWindup + activeLen + 3;
	localparam int timeoutCycles = numRounds * roundLimit + 20;

	logic                  clock;
	logic                  rstN;
	combatPkg::controlsT   controls1;
	combatPkg::controlsT   controls2;
	geometryPkg::boxT      char1;
	geometryPkg::boxT      char2;
	combatPkg::hitReportT  hit1;
	combatPkg::hitReportT  hit2;
	logic                  busy1;
	logic                  busy2;

	int                    seed;
	int                    cycleCount;
	int                    contentionHits;
	int                    hitsSeen;
	int                    missesSeen;

	// Model state per player
	int                    remaining [2];
	logic                  isOpen [2];
	logic                  closeNext [2];
	int                    hitCount [2];
	combatPkg::attackKindT kindM [2];
	logic                  expectHit [2];
	logic                  roundHit [2];

	attackCoprocessor #(
		.jabWindup (jabWindup),
		.longWindup(longWindup),
		.activeLen (activeLen)
	) dut0 (
		.clock    (clock),
		.rstN     (rstN),
		.controls1(controls1),
		.controls2(controls2),
		.char1    (char1),
		.char2    (char2),
		.hit1     (hit1),
		.hit2     (hit2),
		.busy1    (busy1),
		.busy2    (busy2)
	);

	always #50 clock = ~clock;

	always @(posedge clock) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > timeoutCycles) begin
			$display("Timeout: the rounds did not finish within %0d cycles", timeoutCycles);
			$display("CHECKS FAILED");
			$fatal(1, "simulation stopped by timeout");
		end
	end

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "simulation stopped at first mismatch");
		end
	endtask

	function automatic int randIn(int lo, int span);
		return lo + int'({$random(seed)} % span);
	endfunction

	// Smash buttons, then A, then B with the stick top bits
	function automatic combatPkg::attackKindT decodeKind(combatPkg::controlsT c);
		if (c.smashL) return combatPkg::smashL;
		if (c.smashR) return combatPkg::smashR;
		if (c.smashU) return combatPkg::smashU;
		if (c.smashD) return combatPkg::smashD;
		if (c.aButton) return combatPkg::jab;
		if (!c.bButton) return combatPkg::none;
		if (c.stickX[7:5] == 3'b000) return combatPkg::specialL;
		if (c.stickX[7:5] == 3'b111) return combatPkg::specialR;
		if (c.stickY[7:5] == 3'b111) return combatPkg::specialU;
		if (c.stickY[7:5] == 3'b000) return combatPkg::specialD;
		return combatPkg::specialN;
	endfunction

	function automatic geometryPkg::boxT hitboxOf(geometryPkg::boxT self,
		combatPkg::attackKindT kind, logic facing);
		geometryPkg::boxT hb;
		geometryPkg::dirT dir;
		int x;
		int y;
		int w;
		int h;
		x = self.pos.x;
		y = self.pos.y;
		w = self.size.x;
		h = self.size.y;
		case (kind)
			combatPkg::smashL, combatPkg::specialL: dir = geometryPkg::left;
			combatPkg::smashR, combatPkg::specialR: dir = geometryPkg::right;
			combatPkg::smashU, combatPkg::specialU: dir = geometryPkg::up;
			combatPkg::smashD, combatPkg::specialD: dir = geometryPkg::down;
			default: dir = facing ? geometryPkg::right : geometryPkg::left;
		endcase
		hb.size.x = w / 2;
		hb.size.y = h / 2;
		case (dir)
			geometryPkg::left: begin
				hb.pos.x = x - w / 2;
				hb.pos.y = y + h / 4;
			end
			geometryPkg::right: begin
				hb.pos.x = x + w;
				hb.pos.y = y + h / 4;
			end
			geometryPkg::up: begin
				hb.pos.x = x + w / 4;
				hb.pos.y = y + h;
			end
			default: begin
				hb.pos.x = x + w / 4;
				hb.pos.y = y - h / 4;
			end
		endcase
		return hb;
	endfunction

	function automatic logic boxesOverlap(geometryPkg::boxT a, geometryPkg::boxT b);
		logic onX;
		logic onY;
		onX = (int'(a.pos.x) < int'(b.pos.x) + int'(b.size.x))
			&& (int'(b.pos.x) < int'(a.pos.x) + int'(a.size.x));
		onY = (int'(a.pos.y) < int'(b.pos.y) + int'(b.size.y))
			&& (int'(b.pos.y) < int'(a.pos.y) + int'(a.size.y));
		return onX && onY;
	endfunction

	// Keeps every edge and hitbox well inside 4096
	function automatic geometryPkg::boxT randomBox();
		geometryPkg::boxT b;
		b.pos.x = randIn(512, 1024);
		b.pos.y = randIn(512, 1024);
		b.size.x = randIn(32, 256);
		b.size.y = randIn(32, 256);
		return b;
	endfunction

	function automatic combatPkg::controlsT quietWord();
		combatPkg::controlsT c;
		c = $random(seed);
		c.smashL = 1'b0;
		c.smashR = 1'b0;
		c.smashU = 1'b0;
		c.smashD = 1'b0;
		c.aButton = 1'b0;
		c.bButton = 1'b0;
		return c;
	endfunction

	// B always held, so every word starts some attack
	function automatic combatPkg::controlsT attackWord();
		combatPkg::controlsT c;
		c = $random(seed);
		if (randIn(0, 4) != 0) begin
			c.smashL = 1'b0;
			c.smashR = 1'b0;
			c.smashU = 1'b0;
			c.smashD = 1'b0;
		end
		if (randIn(0, 2) != 0) begin
			c.aButton = 1'b0;
		end
		c.bButton = 1'b1;
		return c;
	endfunction

	task automatic startRound();
		int sel;
		logic swapRoles;
		combatPkg::controlsT w1;
		combatPkg::controlsT w2;
		geometryPkg::boxT b1;
		geometryPkg::boxT b2;
		geometryPkg::boxT hb;
		sel = randIn(0, 4);
		swapRoles = 1'b0;
		b1 = randomBox();
		w1 = attackWord();
		w2 = attackWord();
		roundHit[0] = 1'b0;
		roundHit[1] = 1'b0;
		case (sel)
			0, 1: begin
				// Side by side, both swing at once
				b2 = b1;
				b2.pos.x = b1.pos.x + b1.size.x;
				if (sel == 0) begin
					w1.facingRight = 1'b1;
					w2.facingRight = 1'b0;
				end
			end
			2: begin
				// Defender stands on the attacker's hitbox
				hb = hitboxOf(b1, decodeKind(w1), w1.facingRight);
				b2 = randomBox();
				b2.pos = hb.pos;
				w2 = quietWord();
				swapRoles = (randIn(0, 2) == 1);
			end
			default: begin
				b2 = randomBox();
				b2.pos.x = b1.pos.x + 16'd1500;
			end
		endcase
		if (swapRoles) begin
			char1 = b2;
			char2 = b1;
			controls1 = w2;
			controls2 = w1;
		end else begin
			char1 = b1;
			char2 = b2;
			controls1 = w1;
			controls2 = w2;
		end
	endtask

	task automatic stepCycle();
		int p;
		combatPkg::hitReportT seen;
		combatPkg::controlsT ctl;
		combatPkg::attackKindT kind;
		geometryPkg::boxT own;
		geometryPkg::boxT opp;
		logic busyNow;
		@(posedge clock);
		#1;
		for (p = 0; p < 2; p++) begin
			seen = (p == 0) ? hit1 : hit2;
			ctl = (p == 0) ? controls1 : controls2;
			own = (p == 0) ? char1 : char2;
			opp = (p == 0) ? char2 : char1;
			busyNow = (p == 0) ? busy1 : busy2;
			if (seen.valid) begin
				checkValue($sformatf("p%0d hit inside an attack", p + 1), 1, isOpen[p]);
				checkValue($sformatf("p%0d hit kind", p + 1), kindM[p], seen.kind);
				hitCount[p]++;
			end
			// A late hit may still arrive one cycle after busy falls
			if (closeNext[p]) begin
				checkValue($sformatf("p%0d hits per attack", p + 1), expectHit[p], hitCount[p]);
				if (expectHit[p]) begin
					hitsSeen++;
				end else begin
					missesSeen++;
				end
				roundHit[p] = expectHit[p];
				isOpen[p] = 1'b0;
				closeNext[p] = 1'b0;
			end
			if (remaining[p] > 0) begin
				remaining[p]--;
				closeNext[p] = (remaining[p] == 0);
			end else begin
				kind = decodeKind(ctl);
				if (kind != combatPkg::none) begin
					kindM[p] = kind;
					remaining[p] = ((kind == combatPkg::jab) ? jabWindup : longWindup) + activeLen;
					expectHit[p] = boxesOverlap(hitboxOf(own, kind, ctl.facingRight), opp);
					hitCount[p] = 0;
					isOpen[p] = 1'b1;
				end
			end
			checkValue($sformatf("p%0d busy", p + 1), remaining[p] > 0, busyNow);
		end
		#4;
		// Anything goes while busy, idle players stay off the buttons
		if (remaining[0] > 0) begin
			controls1 = $random(seed);
		end else begin
			controls1 = quietWord();
		end
		if (remaining[1] > 0) begin
			controls2 = $random(seed);
		end else begin
			controls2 = quietWord();
		end
	endtask

	initial begin
		int r;
		clock = 1'b0;
		rstN = 1'b0;
		controls1 = '0;
		controls2 = '0;
		char1 = '0;
		char2 = '0;
		seed = 32'h43df;
		cycleCount = 0;
		contentionHits = 0;
		hitsSeen = 0;
		missesSeen = 0;
		for (r = 0; r < 2; r++) begin
			remaining[r] = 0;
			isOpen[r] = 1'b0;
			closeNext[r] = 1'b0;
			hitCount[r] = 0;
			kindM[r] = combatPkg::none;
			expectHit[r] = 1'b0;
			roundHit[r] = 1'b0;
		end
		repeat (2) @(posedge clock);
		#1;
		checkValue("reset busy1", 0, busy1);
		checkValue("reset busy2", 0, busy2);
		checkValue("reset hit1 valid", 0, hit1.valid);
		checkValue("reset hit2 valid", 0, hit2.valid);
		#4;
		rstN = 1'b1;
		for (r = 0; r < numRounds; r++) begin
			startRound();
			do begin
				stepCycle();
			end while (remaining[0] > 0 || remaining[1] > 0 || closeNext[0] || closeNext[1]);
			if (roundHit[0] && roundHit[1]) begin
				contentionHits++;
			end
		end
		checkValue("rounds where both peers landed", 1, contentionHits > 0);
		checkValue("attacks that landed", 1, hitsSeen > 0);
		checkValue("attacks that missed", 1, missesSeen > 0);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
common/geometryPkg.sv
common/combatPkg.sv
attack/attackDecoder.sv
attack/attackUnit.sv
hw/hitArbiter.sv
hw/attackCoprocessor.sv
tb/attackCoprocessorTb.sv

// File: Bender.yml
package:
  name: attack_coprocessor

sources:
  - common/geometryPkg.sv
  - common/combatPkg.sv
  - attack/attackDecoder.sv
  - attack/attackUnit.sv
  - hw/hitArbiter.sv
  - hw/attackCoprocessor.sv
  - target: simulation
    files:
      - tb/attackCoprocessorTb.sv
